//--- icache.f
src/icache_pkg.sv
src/icache_way.sv
src/icache_resolve.sv
src/icache.sv
sim/icache_mem_model.sv
sim/icache_tb.sv

//--- run.sh
#!/bin/bash
# builds the icache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null; then
	echo "verilator not found in PATH"
	exit 1
fi

verilator --binary --top-module icache_tb -f icache.f -o icache_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit $status
fi

./obj_dir/icache_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished"
exit 0

//--- sim/icache_tb.sv
`timescale 1ns/1ns

module icache_tb;

	logic                               clock;
	logic                               reset;
	logic                               fetch_en;
	logic [icache_pkg::ADDR_BITS-1:0]   fetch_addr;
	logic [icache_pkg::MEM_ID_BITS-1:0] mem_response;
	icache_pkg::mem_fill_t              mem_fill;
	icache_pkg::mem_cmd_t               mem_command;
	logic [icache_pkg::ADDR_BITS-1:0]   mem_addr;
	logic                               fetch_done;
	icache_pkg::fetch_status_t          fetch_status;
	logic [icache_pkg::BLOCK_BITS-1:0]  fetch_data;
	logic [icache_pkg::BLOCK_BITS-1:0]  load_data;

	// reference model indexed by way then set
	logic [icache_pkg::TAG_BITS-1:0]    ref_tag [2][icache_pkg::SETS];
	logic                               ref_valid [2][icache_pkg::SETS];
	logic [icache_pkg::MEM_ID_BITS-1:0] ref_id [2][icache_pkg::SETS];
	logic                               ref_lru [icache_pkg::SETS];

	string                     test_name;
	icache_pkg::fetch_status_t last_status;

	// block contents depend on every address bit
	function automatic logic [icache_pkg::BLOCK_BITS-1:0] block_data(
		input logic [icache_pkg::ADDR_BITS-1:0] baddr);
		return {baddr ^ 16'hc3a5, ~baddr, baddr + 16'h4d17, {baddr[7:0], baddr[15:8]}};
	endfunction

	function automatic logic [icache_pkg::ADDR_BITS-1:0] make_addr(
		input logic [icache_pkg::TAG_BITS-1:0]    tag,
		input logic [icache_pkg::INDEX_BITS-1:0]  index,
		input logic [icache_pkg::OFFSET_BITS-1:0] offset);
		return {tag, index, offset};
	endfunction

	assign load_data = block_data(mem_addr);

	icache u_icache
	(
		.clock        (clock),
		.reset        (reset),
		.fetch_en     (fetch_en),
		.fetch_addr   (fetch_addr),
		.mem_response (mem_response),
		.mem_fill     (mem_fill),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.fetch_done   (fetch_done),
		.fetch_status (fetch_status),
		.fetch_data   (fetch_data)
	);

	icache_mem_model u_mem
	(
		.clock        (clock),
		.reset        (reset),
		.mem_command  (mem_command),
		.load_data    (load_data),
		.mem_response (mem_response),
		.mem_fill     (mem_fill)
	);

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#10 clock = ~clock;
		end
	end

	task automatic check(input string test, input string what,
		input logic [63:0] expected, input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("Error: test %s, %s: expected %h, actual %h", test, what, expected, actual);
			$display("TB FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// a fill seen now lands in the arrays at the next edge
	task automatic absorb_fill(input icache_pkg::mem_fill_t fill);
		if (fill.id != '0)
		begin
			for (int w = 0; w < 2; w++)
			begin
				for (int s = 0; s < icache_pkg::SETS; s++)
				begin
					if (ref_id[w][s] == fill.id)
					begin
						ref_valid[w][s] = 1'b1;
						ref_id[w][s]    = '0;
					end
				end
			end
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(negedge clock);
			absorb_fill(mem_fill);
		end
	endtask

	task automatic fetch_check(input logic [icache_pkg::ADDR_BITS-1:0] addr);
		icache_pkg::fetch_addr_t          f;
		icache_pkg::fetch_status_t        expected;
		logic [icache_pkg::ADDR_BITS-1:0] baddr;
		logic                             hit0;
		logic                             hit1;
		logic                             pend;
		logic                             victim;
		f     = icache_pkg::fetch_addr_t'(addr);
		baddr = {f.tag, f.index, {icache_pkg::OFFSET_BITS{1'b0}}};
		@(posedge clock);
		fetch_en   <= 1'b1;
		fetch_addr <= addr;
		@(negedge clock);
		check(test_name, "done before result", 64'(1'b0), 64'(fetch_done));
		hit0   = ref_valid[0][f.index] && (ref_tag[0][f.index] == f.tag);
		hit1   = ref_valid[1][f.index] && (ref_tag[1][f.index] == f.tag);
		pend   = (ref_id[0][f.index] != '0 && ref_tag[0][f.index] == f.tag)
			|| (ref_id[1][f.index] != '0 && ref_tag[1][f.index] == f.tag);
		victim = ref_lru[f.index];
		if (hit0 || hit1)
		begin
			expected         = icache_pkg::FETCH_HIT;
			ref_lru[f.index] = hit0;
		end
		else if (pend)
			expected = icache_pkg::FETCH_PENDING;
		else if (ref_id[victim][f.index] != '0)
			expected = icache_pkg::FETCH_STALL;
		else
		begin
			expected                  = icache_pkg::FETCH_MISS;
			ref_tag[victim][f.index]   = f.tag;
			ref_valid[victim][f.index] = 1'b0;
			ref_id[victim][f.index]    = mem_response;
			ref_lru[f.index]           = ~victim;
		end
		check(test_name, "load issued", 64'(expected == icache_pkg::FETCH_MISS),
			64'(mem_command == icache_pkg::MEM_LOAD));
		if (expected == icache_pkg::FETCH_MISS)
			check(test_name, "load address", 64'(baddr), 64'(mem_addr));
		absorb_fill(mem_fill);
		@(posedge clock);
		fetch_en <= 1'b0;
		@(negedge clock);
		check(test_name, "fetch done", 64'(1'b1), 64'(fetch_done));
		check(test_name, "status", 64'(expected), 64'(fetch_status));
		check(test_name, "data", (expected == icache_pkg::FETCH_HIT) ? block_data(baddr) : '0,
			fetch_data);
		check(test_name, "load after decision", 64'(icache_pkg::MEM_NONE), 64'(mem_command));
		last_status = fetch_status;
		absorb_fill(mem_fill);
	endtask

	task automatic expect_status(input string what, input icache_pkg::fetch_status_t status);
		check(test_name, what, 64'(status), 64'(last_status));
	endtask

	task automatic reset_then_miss();
		test_name = "reset_miss";
		check(test_name, "done after reset", 64'(1'b0), 64'(fetch_done));
		check(test_name, "command after reset", 64'(icache_pkg::MEM_NONE), 64'(mem_command));
		fetch_check(make_addr(8'h12, 5'd3, 3'd5));
		expect_status("first fetch", icache_pkg::FETCH_MISS);
		idle(6);
	endtask

	task automatic hit_after_fill();
		test_name = "hit_after_fill";
		fetch_check(make_addr(8'h21, 5'd7, 3'd2));
		idle(6);
		fetch_check(make_addr(8'h21, 5'd7, 3'd2));
		expect_status("retry", icache_pkg::FETCH_HIT);
		fetch_check(make_addr(8'h21, 5'd7, 3'd6));
		expect_status("other offset", icache_pkg::FETCH_HIT);
	endtask

	task automatic refetch_pending();
		test_name = "pending";
		fetch_check(make_addr(8'h33, 5'd11, 3'd0));
		fetch_check(make_addr(8'h33, 5'd11, 3'd4));
		expect_status("refetch in flight", icache_pkg::FETCH_PENDING);
		idle(6);
	endtask

	task automatic lru_eviction();
		test_name = "eviction";
		fetch_check(make_addr(8'h40, 5'd14, 3'd0));
		fetch_check(make_addr(8'h41, 5'd14, 3'd0));
		idle(6);
		fetch_check(make_addr(8'h40, 5'd14, 3'd1));
		expect_status("first tag", icache_pkg::FETCH_HIT);
		fetch_check(make_addr(8'h41, 5'd14, 3'd2));
		expect_status("second tag", icache_pkg::FETCH_HIT);
		// least recently used is the first tag now
		fetch_check(make_addr(8'h42, 5'd14, 3'd3));
		expect_status("third tag", icache_pkg::FETCH_MISS);
		idle(6);
		fetch_check(make_addr(8'h41, 5'd14, 3'd4));
		expect_status("kept tag", icache_pkg::FETCH_HIT);
		fetch_check(make_addr(8'h40, 5'd14, 3'd5));
		expect_status("evicted tag", icache_pkg::FETCH_MISS);
		idle(6);
	endtask

	task automatic stall_and_refusal();
		test_name = "stall_refuse";
		fetch_check(make_addr(8'h50, 5'd18, 3'd0));
		fetch_check(make_addr(8'h51, 5'd18, 3'd0));
		fetch_check(make_addr(8'h52, 5'd18, 3'd0));
		expect_status("both ways pending", icache_pkg::FETCH_STALL);
		idle(6);
		u_mem.refuse_next();
		fetch_check(make_addr(8'h53, 5'd18, 3'd1));
		expect_status("refused load", icache_pkg::FETCH_MISS);
		fetch_check(make_addr(8'h53, 5'd18, 3'd1));
		expect_status("retry after refusal", icache_pkg::FETCH_MISS);
		idle(6);
		fetch_check(make_addr(8'h53, 5'd18, 3'd7));
		expect_status("accepted retry", icache_pkg::FETCH_HIT);
	endtask

	task automatic random_retries();
		logic [icache_pkg::ADDR_BITS-1:0] addr;
		test_name = "random";
		repeat (300)
		begin
			addr = make_addr(8'(16 + $urandom_range(2)), 5'(20 + $urandom_range(3)),
				3'($urandom_range(7)));
			fetch_check(addr);
			while (last_status != icache_pkg::FETCH_HIT)
			begin
				fetch_check(addr);
			end
		end
		idle(6);
	endtask

	// fetch counts per test times at most ten cycles per fetch
	initial
	begin
		repeat (2 + (1 + 3 + 2 + 7 + 6 + 300) * 10) @(posedge clock);
		$display("watchdog expired before the tests finished");
		$display("TB FAILED");
		$fatal(1, "timeout");
	end

	initial
	begin
		void'($urandom(41696));
		reset      = 1'b1;
		fetch_en   = 1'b0;
		fetch_addr = '0;
		for (int s = 0; s < icache_pkg::SETS; s++)
		begin
			ref_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++)
			begin
				ref_tag[w][s]   = '0;
				ref_valid[w][s] = 1'b0;
				ref_id[w][s]    = '0;
			end
		end
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		idle(1);
		reset_then_miss();
		hit_after_fill();
		refetch_pending();
		lru_eviction();
		stall_and_refusal();
		random_retries();
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- sim/icache_mem_model.sv
`timescale 1ns/1ns

module icache_mem_model
(
	input  logic                               clock,
	input  logic                               reset,
	input  icache_pkg::mem_cmd_t               mem_command,
	input  logic [icache_pkg::BLOCK_BITS-1:0]  load_data,
	output logic [icache_pkg::MEM_ID_BITS-1:0] mem_response,
	output icache_pkg::mem_fill_t              mem_fill
);

	logic [(1 << icache_pkg::MEM_ID_BITS)-1:0] outstanding;
	logic [icache_pkg::MEM_ID_BITS-1:0]        next_id;
	logic [icache_pkg::MEM_ID_BITS-1:0]        free_id;
	logic                                      refusing;

	// five stage return pipe, one fill per cycle at most
	icache_pkg::mem_fill_t pipe [5];

	int refuse_asked = 0;
	int refuse_used;

	// the next load gets id 0
	task refuse_next();
		refuse_asked = refuse_asked + 1;
	endtask

	// ids 1 to 15 in rotation, skipping outstanding ones
	always_comb
	begin
		int cand;
		free_id = '0;
		for (int k = 0; k < 15; k++)
		begin
			cand = (int'(next_id) + k - 1) % 15 + 1;
			if (free_id == '0 && !outstanding[cand])
			begin
				free_id = cand[icache_pkg::MEM_ID_BITS-1:0];
			end
		end
	end

	always_comb
	begin
		refusing     = refuse_asked != refuse_used;
		mem_response = '0;
		if (mem_command == icache_pkg::MEM_LOAD && !refusing)
		begin
			mem_response = free_id;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			next_id     <= 4'd1;
			outstanding <= '0;
			refuse_used <= 0;
			for (int k = 0; k < 5; k++)
			begin
				pipe[k] <= '0;
			end
		end
		else
		begin
			if (mem_command == icache_pkg::MEM_LOAD && refusing)
			begin
				refuse_used <= refuse_used + 1;
			end
			if (mem_response != '0)
			begin
				outstanding[mem_response] <= 1'b1;
				next_id      <= (mem_response == '1) ? 4'd1 : mem_response + 4'd1;
				pipe[0].id   <= mem_response;
				pipe[0].data <= load_data;
			end
			else
			begin
				pipe[0] <= '0;
			end
			// id is free again once its fill is taken
			if (mem_fill.id != '0)
			begin
				outstanding[mem_fill.id] <= 1'b0;
			end
			for (int k = 1; k < 5; k++)
			begin
				pipe[k] <= pipe[k-1];
			end
		end
	end

	assign mem_fill = pipe[4];

endmodule

//--- src/icache.sv
`timescale 1ns/1ns

module icache
(
	input  logic                               clock,
	input  logic                               reset,
	input  logic                               fetch_en,
	input  logic [icache_pkg::ADDR_BITS-1:0]   fetch_addr,
	input  logic [icache_pkg::MEM_ID_BITS-1:0] mem_response,
	input  icache_pkg::mem_fill_t              mem_fill,
	output icache_pkg::mem_cmd_t               mem_command,
	output logic [icache_pkg::ADDR_BITS-1:0]   mem_addr,
	output logic                               fetch_done,
	output icache_pkg::fetch_status_t          fetch_status,
	output logic [icache_pkg::BLOCK_BITS-1:0]  fetch_data
);

	icache_pkg::fetch_addr_t          addr_fields;
	logic [icache_pkg::ADDR_BITS-1:0] block_addr;

	icache_pkg::way_lookup_t way0_lookup;
	icache_pkg::way_lookup_t way1_lookup;
	icache_pkg::way_alloc_t  way0_alloc;
	icache_pkg::way_alloc_t  way1_alloc;

	assign addr_fields = icache_pkg::fetch_addr_t'(fetch_addr);
	// offset cleared for the memory request
	assign block_addr  = {addr_fields.tag, addr_fields.index, {icache_pkg::OFFSET_BITS{1'b0}}};

	icache_way u_way0
	(
		.clock    (clock),
		.reset    (reset),
		.index    (addr_fields.index),
		.tag      (addr_fields.tag),
		.alloc    (way0_alloc),
		.mem_fill (mem_fill),
		.lookup   (way0_lookup)
	);

	icache_way u_way1
	(
		.clock    (clock),
		.reset    (reset),
		.index    (addr_fields.index),
		.tag      (addr_fields.tag),
		.alloc    (way1_alloc),
		.mem_fill (mem_fill),
		.lookup   (way1_lookup)
	);

	icache_resolve u_resolve
	(
		.clock        (clock),
		.reset        (reset),
		.fetch_en     (fetch_en),
		.index        (addr_fields.index),
		.block_addr   (block_addr),
		.way0         (way0_lookup),
		.way1         (way1_lookup),
		.mem_response (mem_response),
		.alloc0       (way0_alloc),
		.alloc1       (way1_alloc),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.fetch_done   (fetch_done),
		.fetch_status (fetch_status),
		.fetch_data   (fetch_data)
	);

endmodule

//--- src/icache_resolve.sv
`timescale 1ns/1ns

module icache_resolve
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic                              fetch_en,
	input  logic [icache_pkg::INDEX_BITS-1:0] index,
	input  logic [icache_pkg::ADDR_BITS-1:0]  block_addr,
	input  icache_pkg::way_lookup_t           way0,
	input  icache_pkg::way_lookup_t           way1,
	input  logic [icache_pkg::MEM_ID_BITS-1:0] mem_response,
	output icache_pkg::way_alloc_t            alloc0,
	output icache_pkg::way_alloc_t            alloc1,
	output icache_pkg::mem_cmd_t              mem_command,
	output logic [icache_pkg::ADDR_BITS-1:0]  mem_addr,
	output logic                              fetch_done,
	output icache_pkg::fetch_status_t         fetch_status,
	output logic [icache_pkg::BLOCK_BITS-1:0] fetch_data
);

	// lru bit names the victim way of each set
	logic [icache_pkg::SETS-1:0] lru;

	icache_pkg::fetch_addr_t   block_fields;
	icache_pkg::fetch_status_t status;
	icache_pkg::way_alloc_t    alloc_base;

	logic                              victim;
	logic                              victim_busy;
	logic                              any_hit;
	logic                              any_pending;
	logic                              miss;
	logic [icache_pkg::BLOCK_BITS-1:0] hit_data;

	always_comb
	begin
		block_fields = icache_pkg::fetch_addr_t'(block_addr);
	end

	always_comb
	begin
		victim      = lru[index];
		victim_busy = victim ? way1.busy : way0.busy;
		any_hit     = way0.hit || way1.hit;
		any_pending = way0.pending_match || way1.pending_match;
		hit_data    = way0.hit ? way0.data : way1.data;
	end

	// status priority: hit, pending, stall, miss
	always_comb
	begin
		if (any_hit)
		begin
			status = icache_pkg::FETCH_HIT;
		end
		else if (any_pending)
		begin
			status = icache_pkg::FETCH_PENDING;
		end
		else if (victim_busy)
		begin
			status = icache_pkg::FETCH_STALL;
		end
		else
		begin
			status = icache_pkg::FETCH_MISS;
		end
		miss = fetch_en && (status == icache_pkg::FETCH_MISS);
	end

	// memory command, same cycle as the miss decision
	always_comb
	begin
		mem_command = miss ? icache_pkg::MEM_LOAD : icache_pkg::MEM_NONE;
		mem_addr    = block_addr;
	end

	// allocation goes to the victim only
	always_comb
	begin
		alloc_base.enable = 1'b0;
		alloc_base.index  = index;
		alloc_base.tag    = block_fields.tag;
		alloc_base.id     = mem_response;

		alloc0        = alloc_base;
		alloc0.enable = miss && (victim == 1'b0);
		alloc1        = alloc_base;
		alloc1.enable = miss && (victim == 1'b1);
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			lru <= '0;
		end
		else if (fetch_en)
		begin
			if (any_hit)
			begin
				// point at the way that did not hit
				lru[index] <= way0.hit;
			end
			else if (miss)
			begin
				lru[index] <= ~lru[index];
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			fetch_done <= 1'b0;
		end
		else
		begin
			fetch_done <= fetch_en;
		end
	end

	// result payload
	always_ff @(posedge clock)
	begin
		if (fetch_en)
		begin
			fetch_status <= status;
			fetch_data   <= any_hit ? hit_data : '0;
		end
	end

endmodule

//--- src/icache_way.sv
`timescale 1ns/1ns

module icache_way
(
	input  logic                              clock,
	input  logic                              reset,
	input  logic [icache_pkg::INDEX_BITS-1:0] index,
	input  logic [icache_pkg::TAG_BITS-1:0]   tag,
	input  icache_pkg::way_alloc_t            alloc,
	input  icache_pkg::mem_fill_t             mem_fill,
	output icache_pkg::way_lookup_t           lookup
);

	// per-set storage
	logic [icache_pkg::TAG_BITS-1:0]    tag_mem [icache_pkg::SETS];
	logic [icache_pkg::BLOCK_BITS-1:0]  data_mem [icache_pkg::SETS];
	logic [icache_pkg::MEM_ID_BITS-1:0] id_mem [icache_pkg::SETS];
	logic [icache_pkg::SETS-1:0]        valid_mem;

	// lookup terms for the addressed set
	logic tag_equal;
	logic entry_busy;

	// fill match per set
	logic                        fill_live;
	logic [icache_pkg::SETS-1:0] fill_hit;

	always_comb
	begin
		tag_equal  = tag_mem[index] == tag;
		entry_busy = id_mem[index] != '0;
	end

	always_comb
	begin
		lookup.hit           = valid_mem[index] && tag_equal;
		lookup.pending_match = entry_busy && tag_equal;
		lookup.busy          = entry_busy;
		lookup.data          = data_mem[index];
	end

	// ids are unique, so at most one set matches
	always_comb
	begin
		fill_live = mem_fill.id != '0;
		for (int s = 0; s < icache_pkg::SETS; s++)
		begin
			fill_hit[s] = fill_live && (id_mem[s] == mem_fill.id);
		end
	end

	// valid bits and pending ids
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid_mem <= '0;
			for (int s = 0; s < icache_pkg::SETS; s++)
			begin
				id_mem[s] <= '0;
			end
		end
		else
		begin
			if (alloc.enable)
			begin
				valid_mem[alloc.index] <= 1'b0;
				id_mem[alloc.index]    <= alloc.id;
			end
			// victim is never busy, so a fill never lands on the allocated set
			for (int s = 0; s < icache_pkg::SETS; s++)
			begin
				if (fill_hit[s])
				begin
					valid_mem[s] <= 1'b1;
					id_mem[s]    <= '0;
				end
			end
		end
	end

	// tags and block data
	always_ff @(posedge clock)
	begin
		if (alloc.enable)
		begin
			tag_mem[alloc.index] <= alloc.tag;
		end
		for (int s = 0; s < icache_pkg::SETS; s++)
		begin
			if (fill_hit[s])
			begin
				data_mem[s] <= mem_fill.data;
			end
		end
	end

endmodule

//--- src/icache_pkg.sv
package icache_pkg;

	// address layout
	localparam int ADDR_BITS   = 16;
	localparam int OFFSET_BITS = 3;
	localparam int INDEX_BITS  = 5;
	localparam int SETS        = 1 << INDEX_BITS;
	localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

	localparam int BLOCK_BITS  = 64;

	// id 0 means no transaction
	localparam int MEM_ID_BITS = 4;

	typedef struct packed
	{
		logic [TAG_BITS-1:0]    tag;
		logic [INDEX_BITS-1:0]  index;
		logic [OFFSET_BITS-1:0] offset;
	} fetch_addr_t;

	typedef enum logic
	{
		MEM_NONE,
		MEM_LOAD
	} mem_cmd_t;

	typedef enum logic [1:0]
	{
		FETCH_HIT,
		FETCH_MISS,
		FETCH_PENDING,
		FETCH_STALL
	} fetch_status_t;

	// one way's answer for the addressed set
	typedef struct packed
	{
		logic                  hit;
		logic                  pending_match;
		logic                  busy;
		logic [BLOCK_BITS-1:0] data;
	} way_lookup_t;

	typedef struct packed
	{
		logic                   enable;
		logic [INDEX_BITS-1:0]  index;
		logic [TAG_BITS-1:0]    tag;
		logic [MEM_ID_BITS-1:0] id;
	} way_alloc_t;

	typedef struct packed
	{
		logic [MEM_ID_BITS-1:0] id;
		logic [BLOCK_BITS-1:0]  data;
	} mem_fill_t;

endpackage
